//--- design/icache_pkg.sv
package icache_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int ADDR_W      = 32;
    localparam int WORD_W      = 32;
    localparam int BLOCK_WORDS = 8;
    localparam int OFFSET_W    = 5;   // byte offset inside one block
    localparam int WAY_NUM     = 2;

    ////////////////////////////////////////
    // cache enums
    ////////////////////////////////////////

    // the ways decode only the write states, the rest is for the controller
    typedef enum logic [2:0] {
        ICACHE_IDLE,
        ICACHE_LOOKUP,
        ICACHE_HIT_CHECK,
        ICACHE_LOAD,
        ICACHE_WRITE,
        ICACHE_WRITE_TAG,
        ICACHE_INDEX_WRITE_V,
        ICACHE_HIT_WRITE_V
    } icache_state_t;

    typedef enum logic [1:0] {
        CACOP_STORE_TAG,
        CACOP_INDEX_INV,
        CACOP_HIT_INV
    } cacop_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        cacop_t            code;
        logic [ADDR_W-1:0] addr;   // bit 0 picks the way for the index operations
    } cacop_req_t;

    typedef struct packed {
        logic [BLOCK_WORDS*WORD_W-1:0] data;   // word 0 sits in the low bits
    } refill_t;

endpackage

//--- design/sdp_ram.sv
module sdp_ram #(
    parameter int WIDTH   = 32,
    parameter int DEPTH_W = 7
) (
    input  logic               clk,
    input  logic               wen,
    input  logic [DEPTH_W-1:0] waddr,
    input  logic [WIDTH-1:0]   wdata,
    input  logic [DEPTH_W-1:0] raddr,
    output logic [WIDTH-1:0]   rdata
);

    logic [WIDTH-1:0] mem [2**DEPTH_W];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // read before write, so a write shows up on a read issued one cycle later
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- design/icache_ways.sv
module icache_ways #(
    parameter int INDEX_W = 7
) (
    input  logic                          clk,
    input  icache_pkg::icache_state_t     state,
    input  logic [icache_pkg::ADDR_W-1:0] rd_addr,
    input  logic [icache_pkg::ADDR_W-1:0] cmp_addr,
    input  logic                          select_way,
    input  logic                          lru_wen,
    input  icache_pkg::refill_t           refill,
    output logic                          hit,
    output logic [icache_pkg::WORD_W-1:0] ins,
    output logic                          lru_way
);

    localparam int WAYS    = icache_pkg::WAY_NUM;
    localparam int TAG_W   = icache_pkg::ADDR_W - INDEX_W - icache_pkg::OFFSET_W;
    localparam int BLOCK_W = icache_pkg::BLOCK_WORDS * icache_pkg::WORD_W;

    logic [INDEX_W-1:0]                 rd_index;
    logic [INDEX_W-1:0]                 cmp_index;
    logic [TAG_W-1:0]                   rd_tag;
    logic [TAG_W-1:0]                   cmp_tag;
    logic [icache_pkg::OFFSET_W-3:0]    word_sel;
    icache_pkg::refill_t                refill_q;

    logic [BLOCK_W-1:0] way_rdata [WAYS];
    logic [TAG_W-1:0]   way_rtag [WAYS];
    logic               way_rv [WAYS];
    logic [TAG_W-1:0]   wtag;
    logic               wv;
    logic [WAYS-1:0]    data_wen;
    logic [WAYS-1:0]    tag_wen;
    logic [WAYS-1:0]    v_wen;
    logic [WAYS-1:0]    way_hit;
    logic [BLOCK_W-1:0] hit_block;
    logic               lru_we;
    logic               lru_wdata;

    assign rd_index  = rd_addr[icache_pkg::OFFSET_W +: INDEX_W];
    assign cmp_index = cmp_addr[icache_pkg::OFFSET_W +: INDEX_W];
    assign rd_tag    = rd_addr[icache_pkg::ADDR_W-1 -: TAG_W];
    assign cmp_tag   = cmp_addr[icache_pkg::ADDR_W-1 -: TAG_W];
    assign word_sel  = cmp_addr[icache_pkg::OFFSET_W-1:2];

    // the block arrives with mem_valid, one cycle ahead of the write state
    always_ff @(posedge clk) begin
        refill_q <= refill;
    end

    ////////////////////////////////////////
    // write decode
    ////////////////////////////////////////

    assign wtag = (state == icache_pkg::ICACHE_WRITE) ? rd_tag : '0;
    assign wv   = (state == icache_pkg::ICACHE_WRITE);

    always_comb begin
        data_wen = '0;
        tag_wen  = '0;
        v_wen    = '0;
        unique case (state)
            icache_pkg::ICACHE_WRITE: begin
                data_wen[select_way] = 1'b1;
                tag_wen[select_way]  = 1'b1;
                v_wen[select_way]    = 1'b1;
            end
            icache_pkg::ICACHE_WRITE_TAG:     tag_wen[rd_addr[0]] = 1'b1;
            icache_pkg::ICACHE_INDEX_WRITE_V: v_wen[rd_addr[0]] = 1'b1;
            icache_pkg::ICACHE_HIT_WRITE_V:   v_wen = way_hit;
            default: begin
                data_wen = '0;
            end
        endcase
    end

    // an invalidated way is marked least recently used so that it is refilled first
    assign lru_we    = lru_wen || (state == icache_pkg::ICACHE_INDEX_WRITE_V);
    assign lru_wdata = (state == icache_pkg::ICACHE_INDEX_WRITE_V) ? ~rd_addr[0] : way_hit[1];

    ////////////////////////////////////////
    // compare and word select
    ////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = way_rv[w] && (way_rtag[w] == cmp_tag);
        end
    end

    assign hit       = |way_hit;
    assign hit_block = way_hit[1] ? way_rdata[1] : way_rdata[0];
    assign ins       = hit_block[word_sel*icache_pkg::WORD_W +: icache_pkg::WORD_W];

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        sdp_ram #(.WIDTH(BLOCK_W), .DEPTH_W(INDEX_W)) data_ram (
            .clk   (clk),
            .wen   (data_wen[w]),
            .waddr (rd_index),
            .wdata (refill_q.data),
            .raddr (rd_index),
            .rdata (way_rdata[w])
        );

        sdp_ram #(.WIDTH(TAG_W), .DEPTH_W(INDEX_W)) tag_ram (
            .clk   (clk),
            .wen   (tag_wen[w]),
            .waddr (rd_index),
            .wdata (wtag),
            .raddr (rd_index),
            .rdata (way_rtag[w])
        );

        sdp_ram #(.WIDTH(1), .DEPTH_W(INDEX_W)) valid_ram (
            .clk   (clk),
            .wen   (v_wen[w]),
            .waddr (rd_index),
            .wdata (wv),
            .raddr (rd_index),
            .rdata (way_rv[w])
        );
    end

    sdp_ram #(.WIDTH(1), .DEPTH_W(INDEX_W)) lru_ram (
        .clk   (clk),
        .wen   (lru_we),
        .waddr (cmp_index),   // equals rd_index during the index write state
        .wdata (lru_wdata),
        .raddr (rd_index),
        .rdata (lru_way)
    );

endmodule

//--- design/icache_ctrl.sv
module icache_ctrl #(
    parameter int INDEX_W = 7
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch,
    input  icache_pkg::fetch_req_t        fetch_req,
    input  logic                          cacop,
    input  icache_pkg::cacop_req_t        cacop_req,
    input  logic                          mem_valid,
    input  logic                          hit,
    input  logic                          lru_way,
    output logic                          busy,
    output logic                          ins_valid,
    output logic                          mem_req,
    output logic [icache_pkg::ADDR_W-1:0] mem_addr,
    output icache_pkg::icache_state_t     state,
    output logic [icache_pkg::ADDR_W-1:0] rd_addr,
    output logic [icache_pkg::ADDR_W-1:0] cmp_addr,
    output logic                          select_way,
    output logic                          lru_wen
);

    localparam int TAG_W = icache_pkg::ADDR_W - INDEX_W - icache_pkg::OFFSET_W;

    logic               is_fetch;
    icache_pkg::cacop_t code_q;
    logic               fetch_hit;
    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] req_index;

    assign req_tag   = rd_addr[icache_pkg::ADDR_W-1 -: TAG_W];
    assign req_index = rd_addr[icache_pkg::OFFSET_W +: INDEX_W];

    assign fetch_hit = (state == icache_pkg::ICACHE_HIT_CHECK) && is_fetch && hit;
    assign ins_valid = fetch_hit;
    assign lru_wen   = fetch_hit;
    assign busy      = (state != icache_pkg::ICACHE_IDLE);

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= icache_pkg::ICACHE_IDLE;
            is_fetch   <= 1'b0;
            code_q     <= icache_pkg::CACOP_STORE_TAG;
            select_way <= 1'b0;
            mem_req    <= 1'b0;
        end else begin
            mem_req <= 1'b0;
            unique case (state)
                icache_pkg::ICACHE_IDLE: begin
                    if (fetch) begin
                        is_fetch <= 1'b1;
                        state    <= icache_pkg::ICACHE_LOOKUP;
                    end else if (cacop) begin
                        is_fetch <= 1'b0;
                        code_q   <= cacop_req.code;
                        state    <= icache_pkg::ICACHE_LOOKUP;
                    end
                end
                icache_pkg::ICACHE_LOOKUP: begin
                    if (is_fetch || code_q == icache_pkg::CACOP_HIT_INV) begin
                        state <= icache_pkg::ICACHE_HIT_CHECK;
                    end else if (code_q == icache_pkg::CACOP_STORE_TAG) begin
                        state <= icache_pkg::ICACHE_WRITE_TAG;
                    end else begin
                        state <= icache_pkg::ICACHE_INDEX_WRITE_V;
                    end
                end
                icache_pkg::ICACHE_HIT_CHECK: begin
                    if (!is_fetch) begin
                        state <= icache_pkg::ICACHE_HIT_WRITE_V;   // clears nothing on a miss
                    end else if (hit) begin
                        state <= icache_pkg::ICACHE_IDLE;
                    end else begin
                        state      <= icache_pkg::ICACHE_LOAD;
                        select_way <= ~lru_way;   // victim is the way not used last
                        mem_req    <= 1'b1;
                    end
                end
                icache_pkg::ICACHE_LOAD: begin
                    if (mem_valid) begin
                        state <= icache_pkg::ICACHE_WRITE;
                    end
                end
                icache_pkg::ICACHE_WRITE:         state <= icache_pkg::ICACHE_LOOKUP;
                icache_pkg::ICACHE_WRITE_TAG:     state <= icache_pkg::ICACHE_IDLE;
                icache_pkg::ICACHE_INDEX_WRITE_V: state <= icache_pkg::ICACHE_IDLE;
                icache_pkg::ICACHE_HIT_WRITE_V:   state <= icache_pkg::ICACHE_IDLE;
                default:                          state <= icache_pkg::ICACHE_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // address registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == icache_pkg::ICACHE_IDLE) begin
            if (fetch) begin
                rd_addr <= fetch_req.addr;
            end else if (cacop) begin
                rd_addr <= cacop_req.addr;
            end
        end
        cmp_addr <= rd_addr;   // one cycle behind, lines up with the read data
    end

    always_ff @(posedge clk) begin
        if (state == icache_pkg::ICACHE_HIT_CHECK && is_fetch && !hit) begin
            mem_addr <= {req_tag, req_index, {icache_pkg::OFFSET_W{1'b0}}};
        end
    end

endmodule

//--- design/icache_top.sv
module icache_top #(
    parameter int INDEX_W = 7
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch,
    input  icache_pkg::fetch_req_t        fetch_req,
    input  logic                          cacop,
    input  icache_pkg::cacop_req_t        cacop_req,
    input  logic                          mem_valid,
    input  icache_pkg::refill_t           mem_refill,
    output logic                          busy,
    output logic                          ins_valid,
    output logic [icache_pkg::WORD_W-1:0] ins,
    output logic                          mem_req,
    output logic [icache_pkg::ADDR_W-1:0] mem_addr
);

    icache_pkg::icache_state_t     state;
    logic [icache_pkg::ADDR_W-1:0] rd_addr;
    logic [icache_pkg::ADDR_W-1:0] cmp_addr;
    logic                          select_way;
    logic                          lru_wen;
    logic                          hit;
    logic                          lru_way;

    icache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .fetch      (fetch),
        .fetch_req  (fetch_req),
        .cacop      (cacop),
        .cacop_req  (cacop_req),
        .mem_valid  (mem_valid),
        .hit        (hit),
        .lru_way    (lru_way),
        .busy       (busy),
        .ins_valid  (ins_valid),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .state      (state),
        .rd_addr    (rd_addr),
        .cmp_addr   (cmp_addr),
        .select_way (select_way),
        .lru_wen    (lru_wen)
    );

    icache_ways #(.INDEX_W(INDEX_W)) u_ways (
        .clk        (clk),
        .state      (state),
        .rd_addr    (rd_addr),
        .cmp_addr   (cmp_addr),
        .select_way (select_way),
        .lru_wen    (lru_wen),
        .refill     (mem_refill),
        .hit        (hit),
        .ins        (ins),
        .lru_way    (lru_way)
    );

endmodule

//--- tb/icache_sva.sv
module icache_sva (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic ins_valid,
    input logic mem_req
);

    int fail_count = 0;   // count of failed assertions

    ////////////////////////////////////////
    // memory request rules
    ////////////////////////////////////////

    req_needs_busy: assert property (@(posedge clk) disable iff (rst) mem_req |-> busy)
        else begin
            $error("mem_req high while the cache is idle");
            fail_count++;
        end

    // a hit ends the fetch, so no refill can start as ins_valid drops
    fall_without_req: assert property (@(posedge clk) disable iff (rst)
        !($fell(ins_valid) && mem_req))
        else begin
            $error("ins_valid fell together with mem_req");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !mem_req)
        else begin
            $error("mem_req right after reset release");
            fail_count++;
        end

endmodule

//--- tb/icache_tb.sv
module icache_tb;

    localparam int INDEX_W = 7;
    localparam int TIMEOUT = 200;

    logic                          clk;
    logic                          rst;
    logic                          fetch;
    icache_pkg::fetch_req_t        fetch_req;
    logic                          cacop;
    icache_pkg::cacop_req_t        cacop_req;
    logic                          mem_valid;
    icache_pkg::refill_t           mem_refill;
    logic                          busy;
    logic                          ins_valid;
    logic [icache_pkg::WORD_W-1:0] ins;
    logic                          mem_req;
    logic [icache_pkg::ADDR_W-1:0] mem_addr;

    integer seed = 67;

    icache_top #(.INDEX_W(INDEX_W)) uut (
        .clk        (clk),
        .rst        (rst),
        .fetch      (fetch),
        .fetch_req  (fetch_req),
        .cacop      (cacop),
        .cacop_req  (cacop_req),
        .mem_valid  (mem_valid),
        .mem_refill (mem_refill),
        .busy       (busy),
        .ins_valid  (ins_valid),
        .ins        (ins),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr)
    );

    bind icache_ctrl icache_sva u_sva (
        .clk       (clk),
        .rst       (rst),
        .busy      (busy),
        .ins_valid (ins_valid),
        .mem_req   (mem_req)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // a failed bound assertion ends the run at the next falling edge
    always @(negedge clk) begin
        if (uut.u_ctrl.u_sva.fail_count != 0) begin
            abort_run("a bound assertion on the controller failed");
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("error at %0t: %s", $time, reason);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // word w of a block is its byte address xor a fixed pattern
    function automatic icache_pkg::refill_t block_data(input logic [31:0] base);
        icache_pkg::refill_t blk;
        for (int w = 0; w < icache_pkg::BLOCK_WORDS; w++) begin
            blk.data[w*icache_pkg::WORD_W +: icache_pkg::WORD_W] = (base + 4*w) ^ 32'hA5A5_0000;
        end
        return blk;
    endfunction

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy) begin
            if (cycles == TIMEOUT) abort_run("busy stayed high for 200 cycles");
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic run_fetch(input logic [31:0] addr, input logic [31:0] exp_ins,
                             input logic [31:0] exp_miss);
        int          cycles;
        int          reqs;
        logic [31:0] block;
        block = (addr >> icache_pkg::OFFSET_W) << icache_pkg::OFFSET_W;
        wait_idle();
        fetch          = 1'b1;
        fetch_req.addr = addr;
        @(negedge clk);
        fetch  = 1'b0;
        cycles = 1;
        reqs   = 0;
        while (!ins_valid) begin
            if (mem_req) begin
                reqs++;
                check_value("mem_addr", mem_addr, block);
            end
            if (cycles == TIMEOUT) abort_run("no ins_valid within 200 cycles of a fetch");
            @(negedge clk);
            cycles++;
        end
        check_value("ins", ins, exp_ins);
        check_value("mem_req count", reqs, exp_miss);
        if (exp_miss == 0) check_value("hit latency", cycles, 2);   // read plus compare
    endtask

    task automatic run_cacop(input icache_pkg::cacop_t code, input logic [31:0] addr,
                             input logic [31:0] exp_busy, input logic [31:0] exp_miss);
        int cycles;
        int reqs;
        wait_idle();
        cacop          = 1'b1;
        cacop_req.code = code;
        cacop_req.addr = addr;
        @(negedge clk);
        cacop  = 1'b0;
        cycles = 0;
        reqs   = 0;
        while (busy) begin
            if (mem_req) reqs++;
            if (cycles == TIMEOUT) abort_run("maintenance operation never finished");
            @(negedge clk);
            cycles++;
        end
        check_value("busy cycles", cycles, exp_busy);
        check_value("mem_req count", reqs, exp_miss);
    endtask

    ////////////////////////////////////////
    // memory model
    ////////////////////////////////////////

    initial begin
        logic [31:0] block_addr;
        int          delay;
        mem_valid  = 1'b0;
        mem_refill = '0;
        forever begin
            @(negedge clk);
            mem_valid = 1'b0;
            if (mem_req) begin
                block_addr = mem_addr;
                delay      = 1 + ($unsigned($random(seed)) % 6);
                repeat (delay) @(negedge clk);
                mem_refill = block_data(block_addr);
                mem_valid  = 1'b1;   // one cycle pulse, cleared at the next falling edge
            end
        end
    end

    ////////////////////////////////////////
    // trace replay
    ////////////////////////////////////////

    initial begin
        int          fd;
        int          n;
        int          ops;
        logic [7:0]  op;
        logic [31:0] t_addr;
        logic [31:0] t_ins;
        logic [31:0] t_miss;
        rst       = 1'b1;
        fetch     = 1'b0;
        fetch_req = '0;
        cacop     = 1'b0;
        cacop_req = '0;
        ops       = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // the arrays power up undefined, so clear both ways of every set
        for (int s = 0; s < 2**INDEX_W; s++) begin
            run_cacop(icache_pkg::CACOP_INDEX_INV, s << icache_pkg::OFFSET_W, 2, 0);
            run_cacop(icache_pkg::CACOP_INDEX_INV, (s << icache_pkg::OFFSET_W) | 1, 2, 0);
        end

        fd = $fopen("tb/icache_trace.txt", "r");
        if (fd == 0) abort_run("cannot open tb/icache_trace.txt");
        n = $fscanf(fd, "%s %h %h %h\n", op, t_addr, t_ins, t_miss);
        while (n == 4) begin
            case (op)
                "F": run_fetch(t_addr, t_ins, t_miss);
                "S": run_cacop(icache_pkg::CACOP_STORE_TAG, t_addr, 2, t_miss);
                "I": run_cacop(icache_pkg::CACOP_INDEX_INV, t_addr, 2, t_miss);
                "H": run_cacop(icache_pkg::CACOP_HIT_INV, t_addr, 3, t_miss);
                default: abort_run("unknown operation in the trace");
            endcase
            ops++;
            n = $fscanf(fd, "%s %h %h %h\n", op, t_addr, t_ins, t_miss);
        end
        $fclose(fd);
        if (ops == 0) abort_run("the trace held no operations");
        wait_idle();

        if (uut.u_ctrl.u_sva.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("%0d assertion failures during the run", uut.u_ctrl.u_sva.fail_count);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

endmodule

//--- verilog.f
design/icache_pkg.sv
design/sdp_ram.sv
design/icache_ways.sv
design/icache_ctrl.sv
design/icache_top.sv
tb/icache_sva.sv
tb/icache_tb.sv

//--- tb/icache_trace.txt
F 00001060 a5a51060 1
F 00001064 a5a51064 0
F 0000107c a5a5107c 0
F 00002060 a5a52060 1
F 00001068 a5a51068 0
F 00003060 a5a53060 1
F 00002064 a5a52064 1
F 00003064 a5a53064 0
I 00000061 00000000 0
F 00003068 a5a53068 0
F 00002068 a5a52068 1
S 00000060 00000000 0
F 0000206c a5a5206c 0
F 0000306c a5a5306c 1
H 00002070 00000000 0
F 00003070 a5a53070 0
F 00002074 a5a52074 1
H 00004060 00000000 0
F 00003074 a5a53074 0
F 00002078 a5a52078 0
I 00000060 00000000 0
F 0000307c a5a5307c 1
F 0000207c a5a5207c 0
F 00005100 a5a55100 1
F 0000511c a5a5511c 0
F 0000afe0 a5a5afe0 1
F 0000affc a5a5affc 0
